//--- filelist.f
+incdir+src
src/cpu_pkg.sv
src/cpu_control.sv
src/alu.sv
src/register_file.sv
src/memory1c.sv
src/pc_control.sv
src/cpu.sv
sim/cpu_checker.sv
sim/tb_cpu.sv

//--- sim/tb_cpu.sv
`include "cpu_config.svh"

module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  typedef logic [`CPU_MEM_AW-1:0] waddr_t;

  localparam int NUM_PROGS  = 20;
  localparam int PROG_WORDS = 64;
  localparam int DATA_BASE  = 512;
  localparam int DATA_WORDS = 64;
  // per program: program load, data load, run, read back, slack
  localparam int MAX_CYCLES = NUM_PROGS * (PROG_WORDS + DATA_WORDS + 64 + DATA_WORDS + 16);

  logic        clk = 1'b0;
  logic        rst;
  logic        load_en;
  logic        load_sel;
  waddr_t      load_addr;
  waddr_t      dbg_addr;
  word_t       load_data;
  word_t       dbg_data;
  word_t       pc;
  logic        hlt;
  logic        check_mem;
  int          check_count;
  int          mismatch_count;
  int          cycle_count = 0;
  logic [31:0] lcg_state = 32'd40;
  word_t       prog [PROG_WORDS];
  word_t       dmem [DATA_WORDS];

  // 8 ns period
  always #4 clk = ~clk;

  cpu DUT (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_sel  (load_sel),
    .load_addr (load_addr),
    .dbg_addr  (dbg_addr),
    .load_data (load_data),
    .dbg_data  (dbg_data),
    .pc        (pc),
    .hlt       (hlt)
  );

  cpu_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .load_en        (load_en),
    .load_sel       (load_sel),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .pc             (pc),
    .hlt            (hlt),
    .check_mem      (check_mem),
    .dbg_addr       (dbg_addr),
    .dbg_data       (dbg_data),
    .check_count    (check_count),
    .mismatch_count (mismatch_count)
  );

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // inputs change 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic build_program();
    word_t    r;
    word_t    val;
    reg_idx_t dst;
    int       max_off;
    for (int i = 0; i < DATA_WORDS; i++) begin
      dmem[i] = next_rand();
    end
    // r1..r9 random, r10 and r11 memory bases, r12 to word 48, r13 to the hlt
    for (int k = 1; k <= 13; k++) begin
      val = (k <= 9)  ? next_rand() :
            (k <= 11) ? word_t'((520 + next_rand() % 49) * 2) :
            (k == 12) ? 16'd96 : word_t'(2 * (PROG_WORDS - 1));
      prog[2*k-2] = {`CPU_OP_LLB, 4'(k), val[7:0]};
      prog[2*k-1] = {`CPU_OP_LHB, 4'(k), val[15:8]};
    end
    for (int i = 26; i < PROG_WORDS - 1; i++) begin
      r   = next_rand();
      // writes go to r0..r9 only, r0 included on purpose
      dst = 4'(r[11:8] % 10);
      case (r[15:12])
        `CPU_OP_LW, `CPU_OP_SW: begin
          prog[i] = {r[15:12], (r[15:12] == `CPU_OP_SW) ? r[11:8] : dst, 3'b101, r[4], r[3:0]};
        end
        `CPU_OP_B: begin
          // forward only, never past the hlt
          max_off = (PROG_WORDS - 2 - i < 8) ? PROG_WORDS - 2 - i : 8;
          prog[i] = {r[15:9], 9'(r[8:0] % (max_off + 1))};
        end
        // rs is r12 before word 48, else r13
        `CPU_OP_BR: prog[i] = {r[15:9], 4'b0110, (i < 48) ? r[0] : 1'b1, 4'h0};
        `CPU_OP_HLT: prog[i] = {`CPU_OP_NOP, r[11:0]};
        default: prog[i] = {r[15:12], dst, r[7:0]};
      endcase
    end
    prog[PROG_WORDS-1] = {`CPU_OP_HLT, 12'h000};
  endtask

  // program words first, then the data window, all under reset
  task automatic load_images();
    rst     = 1'b1;
    load_en = 1'b1;
    for (int i = 0; i < PROG_WORDS + DATA_WORDS; i++) begin
      load_sel  = (i >= PROG_WORDS);
      load_addr = (i < PROG_WORDS) ? waddr_t'(i) : waddr_t'(DATA_BASE + i - PROG_WORDS);
      load_data = (i < PROG_WORDS) ? prog[i] : dmem[i - PROG_WORDS];
      tick();
    end
    load_en = 1'b0;
    rst     = 1'b0;
  endtask

  task automatic run_to_halt();
    while (hlt !== 1'b1) begin
      tick();
    end
  endtask

  // checker compares each debug word at the next edge
  task automatic read_back();
    check_mem = 1'b1;
    for (int i = 0; i < DATA_WORDS; i++) begin
      dbg_addr = waddr_t'(DATA_BASE + i);
      tick();
    end
    check_mem = 1'b0;
  endtask

  task automatic end_run(input logic timed_out);
    $display("checks %0d, mismatches %0d, timeouts %0d", check_count, mismatch_count, timed_out);
    if (!timed_out && mismatch_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("Timeout: the processor did not halt within %0d cycles", MAX_CYCLES);
      end_run(1'b1);
    end
  end

  initial begin
    rst       = 1'b1;
    load_en   = 1'b0;
    load_sel  = 1'b0;
    load_addr = '0;
    load_data = '0;
    dbg_addr  = '0;
    check_mem = 1'b0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program();
      load_images();
      run_to_halt();
      read_back();
    end
    end_run(1'b0);
  end

endmodule

//--- sim/cpu_checker.sv
`include "cpu_config.svh"

module cpu_checker (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load_en,
  input  logic                   load_sel,
  input  logic [`CPU_MEM_AW-1:0] load_addr,
  input  cpu_pkg::word_t         load_data,
  input  cpu_pkg::word_t         pc,
  input  logic                   hlt,
  input  logic                   check_mem,
  input  logic [`CPU_MEM_AW-1:0] dbg_addr,
  input  cpu_pkg::word_t         dbg_data,
  output int                     check_count,
  output int                     mismatch_count
);
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  word_t prog_img [`CPU_MEM_WORDS];
  word_t mem_m    [`CPU_MEM_WORDS];
  word_t regs_m   [16];
  word_t pc_m;
  logic  z_m;
  logic  v_m;
  logic  n_m;
  logic  fresh = 1'b0;
  int    checks = 0;
  int    errors = 0;

  assign check_count    = checks;
  assign mismatch_count = errors;

  task automatic compare(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ge and le built from gt, lt and eq
  function automatic logic cond_met(input cond_t c);
    logic gt;
    gt = !z_m && !n_m;
    case (c)
      3'd0: return !z_m;
      3'd1: return z_m;
      3'd2: return gt;
      3'd3: return n_m;
      3'd4: return gt || z_m;
      3'd5: return n_m || z_m;
      3'd6: return v_m;
      default: return 1'b1;
    endcase
  endfunction

  // one instruction of the reference model
  task automatic step();
    word_t    instr;
    word_t    a;
    word_t    b;
    word_t    res;
    word_t    addr;
    word_t    next_pc;
    reg_idx_t rd;
    logic     wr_reg;
    int       full;
    instr   = prog_img[pc_m[`CPU_MEM_AW:1]];
    rd      = instr[11:8];
    a       = regs_m[instr[7:4]];
    b       = regs_m[instr[3:0]];
    // signed word offset scaled to bytes
    addr    = a + word_t'(2 * int'($signed(instr[3:0])));
    next_pc = pc_m + 16'd2;
    res     = '0;
    wr_reg  = 1'b0;
    compare(pc, pc_m, "pc");
    compare(word_t'(hlt), word_t'(instr[15:12] == `CPU_OP_HLT), "hlt");
    case (instr[15:12])
      `CPU_OP_ADD, `CPU_OP_SUB: begin
        // overflow when the true signed result leaves 16 bits
        full   = (instr[15:12] == `CPU_OP_ADD) ? int'($signed(a)) + int'($signed(b)) :
                                                int'($signed(a)) - int'($signed(b));
        res    = full[15:0];
        v_m    = (full > 32767) || (full < -32768);
        n_m    = res[15];
        z_m    = (res == 16'h0);
        wr_reg = 1'b1;
      end
      `CPU_OP_XOR, `CPU_OP_AND, `CPU_OP_SLL, `CPU_OP_SRA, `CPU_OP_ROR: begin
        case (instr[15:12])
          `CPU_OP_XOR: res = a ^ b;
          `CPU_OP_AND: res = a & b;
          `CPU_OP_SLL: res = a << instr[3:0];
          `CPU_OP_SRA: res = $signed(a) >>> instr[3:0];
          default:     res = (a >> instr[3:0]) | (a << (5'd16 - instr[3:0]));
        endcase
        z_m    = (res == 16'h0);
        wr_reg = 1'b1;
      end
      `CPU_OP_LW: begin
        res    = mem_m[addr[`CPU_MEM_AW:1]];
        wr_reg = 1'b1;
      end
      `CPU_OP_SW: mem_m[addr[`CPU_MEM_AW:1]] = regs_m[rd];
      `CPU_OP_LLB, `CPU_OP_LHB: begin
        res    = (instr[15:12] == `CPU_OP_LLB) ? {regs_m[rd][15:8], instr[7:0]} :
                                                {instr[7:0], regs_m[rd][7:0]};
        wr_reg = 1'b1;
      end
      `CPU_OP_B: begin
        if (cond_met(instr[11:9])) begin
          next_pc = pc_m + 16'd2 + word_t'(2 * int'($signed(instr[8:0])));
        end
      end
      `CPU_OP_BR: begin
        if (cond_met(instr[11:9])) begin
          next_pc = a;
        end
      end
      `CPU_OP_PCS: begin
        res    = pc_m + 16'd2;
        wr_reg = 1'b1;
      end
      `CPU_OP_HLT: next_pc = pc_m;
      default: ;
    endcase
    // r0 stays zero in the model too
    if (wr_reg && rd != 4'd0) begin
      regs_m[rd] = res;
    end
    pc_m = next_pc;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      // snoop the load port for both images
      if (load_en && load_sel) begin
        mem_m[load_addr] = load_data;
      end else if (load_en) begin
        prog_img[load_addr] = load_data;
      end
      for (int i = 0; i < 16; i++) begin
        regs_m[i] = '0;
      end
      pc_m  = '0;
      z_m   = 1'b0;
      v_m   = 1'b0;
      n_m   = 1'b0;
      fresh = 1'b1;
    end else begin
      // state right after reset, before anything executes
      if (fresh) begin
        checks++;
        if (pc !== 16'h0 || hlt !== 1'b0) begin
          errors++;
          $display("Mismatch at %0t: after reset pc is %h and hlt is %b, expected 0000 and 0",
                   $time, pc, hlt);
        end
        fresh = 1'b0;
      end
      if (check_mem) begin
        compare(dbg_data, mem_m[dbg_addr], $sformatf("data word %0d", dbg_addr));
      end
      step();
    end
  end

endmodule

//--- src/cpu.sv
`include "cpu_config.svh"

module cpu (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load_en,
  input  logic                   load_sel,
  input  logic [`CPU_MEM_AW-1:0] load_addr,
  input  logic [`CPU_MEM_AW-1:0] dbg_addr,
  input  cpu_pkg::word_t         load_data,
  output cpu_pkg::word_t         dbg_data,
  output cpu_pkg::word_t         pc,
  output logic                   hlt
);
  import cpu_pkg::*;

  word_t    instr;
  word_t    pc_plus2;
  opcode_t  opcode;
  alu_op_t  alu_op;
  logic     reg_write;
  logic     mem_write;
  logic     mem_to_reg;
  logic     pcs_to_reg;
  logic     src1_from_rd;
  logic     src2_from_rd;
  logic     alu_imm;
  logic     set_zvn;
  logic     set_z;
  logic     is_branch;
  logic     is_branch_reg;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    rs_data;
  word_t    rt_data;
  word_t    dst_data;
  word_t    alu_result;
  flags_t   alu_flags;
  word_t    mem_rdata;
  logic     loading;
  logic [`CPU_MEM_AW-1:0] prog_addr;
  logic [`CPU_MEM_AW-1:0] data_addr;
  word_t    data_wdata;
  logic     prog_wr;
  logic     data_wr;

  // load port owns the memory address only while rst and load_en are high
  assign loading = rst & load_en;

  // byte pc to word index
  assign prog_addr = loading ? load_addr : pc[`CPU_MEM_AW:1];
  assign prog_wr   = loading & ~load_sel;

  memory1c prog_mem (
    .clk      (clk),
    .addr     (prog_addr),
    .wr       (prog_wr),
    .data_in  (load_data),
    .data_out (instr),
    .dbg_addr ('0),
    .dbg_data ()
  );

  assign opcode = instr[15:12];

  cpu_control u_control (
    .opcode        (opcode),
    .alu_op        (alu_op),
    .reg_write     (reg_write),
    .mem_write     (mem_write),
    .mem_to_reg    (mem_to_reg),
    .pcs_to_reg    (pcs_to_reg),
    .src1_from_rd  (src1_from_rd),
    .src2_from_rd  (src2_from_rd),
    .alu_imm       (alu_imm),
    .set_zvn       (set_zvn),
    .set_z         (set_z),
    .is_branch     (is_branch),
    .is_branch_reg (is_branch_reg),
    .halt          (hlt)
  );

  // llb/lhb read rd as source, sw reads its data register from [11:8]
  assign rd = instr[11:8];
  assign rs = src1_from_rd ? instr[11:8] : instr[7:4];
  assign rt = src2_from_rd ? instr[11:8] : instr[3:0];

  // write-back priority: pc+2, then memory, then alu
  assign dst_data = pcs_to_reg ? pc_plus2 : (mem_to_reg ? mem_rdata : alu_result);

  register_file u_regfile (
    .clk       (clk),
    .rst       (rst),
    .src_reg1  (rs),
    .src_reg2  (rt),
    .dst_reg   (rd),
    .write_reg (reg_write),
    .dst_data  (dst_data),
    .src_data1 (rs_data),
    .src_data2 (rt_data)
  );

  alu u_alu (
    .op      (alu_op),
    .a       (rs_data),
    .b       (rt_data),
    .imm     (instr[7:0]),
    .use_imm (alu_imm),
    .result  (alu_result),
    .flags   (alu_flags)
  );

  // garbage fetched during reset never reaches data memory
  assign data_addr  = loading ? load_addr : alu_result[`CPU_MEM_AW:1];
  assign data_wdata = rst ? load_data : rt_data;
  assign data_wr    = rst ? (load_en & load_sel) : mem_write;

  memory1c data_mem (
    .clk      (clk),
    .addr     (data_addr),
    .wr       (data_wr),
    .data_in  (data_wdata),
    .data_out (mem_rdata),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  // br target comes from rs, b offset and cond straight from the instruction
  pc_control u_pc (
    .clk           (clk),
    .rst           (rst),
    .halt          (hlt),
    .is_branch     (is_branch),
    .is_branch_reg (is_branch_reg),
    .set_zvn       (set_zvn),
    .set_z         (set_z),
    .alu_flags     (alu_flags),
    .cond          (instr[11:9]),
    .offset        (instr[8:0]),
    .reg_target    (rs_data),
    .pc            (pc),
    .pc_plus2      (pc_plus2)
  );

endmodule

//--- src/pc_control.sv
module pc_control (
  input  logic            clk,
  input  logic            rst,
  input  logic            halt,
  input  logic            is_branch,
  input  logic            is_branch_reg,
  input  logic            set_zvn,
  input  logic            set_z,
  input  cpu_pkg::flags_t alu_flags,
  input  cpu_pkg::cond_t  cond,
  input  logic [8:0]      offset,
  input  cpu_pkg::word_t  reg_target,
  output cpu_pkg::word_t  pc,
  output cpu_pkg::word_t  pc_plus2
);
  import cpu_pkg::*;

  flags_t flags_q;
  word_t  branch_target;
  word_t  pc_next;
  logic   taken;
  logic   z;
  logic   v;
  logic   n;

  assign pc_plus2 = pc + 16'd2;

  // 9-bit signed word offset, relative to pc+2
  assign branch_target = pc_plus2 + {{6{offset[8]}}, offset, 1'b0};

  assign z = flags_q[FLAG_Z];
  assign v = flags_q[FLAG_V];
  assign n = flags_q[FLAG_N];

  // condition checked against flags left by earlier instructions
  always_comb begin
    case (cond)
      3'b000:  taken = ~z;
      3'b001:  taken = z;
      3'b010:  taken = ~z & ~n;
      3'b011:  taken = n;
      3'b100:  taken = z | ~n;
      3'b101:  taken = z | n;
      3'b110:  taken = v;
      default: taken = 1'b1;
    endcase
  end

  // halt freezes the pc so hlt stays asserted
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (is_branch && taken) begin
      pc_next = branch_target;
    end else if (is_branch_reg && taken) begin
      pc_next = reg_target;
    end else begin
      pc_next = pc_plus2;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // add/sub update all flags, logic and shifts only z
  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else if (set_zvn) begin
      flags_q <= alu_flags;
    end else if (set_z) begin
      flags_q[FLAG_Z] <= alu_flags[FLAG_Z];
    end
  end

endmodule

//--- src/memory1c.sv
`include "cpu_config.svh"

module memory1c (
  input  logic                   clk,
  input  logic [`CPU_MEM_AW-1:0] addr,
  input  logic                   wr,
  input  cpu_pkg::word_t         data_in,
  output cpu_pkg::word_t         data_out,
  input  logic [`CPU_MEM_AW-1:0] dbg_addr,
  output cpu_pkg::word_t         dbg_data
);
  import cpu_pkg::*;

  // word array, contents survive reset
  word_t mem [`CPU_MEM_WORDS];

  // write at the rising edge
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[addr] <= data_in;
    end
  end

  // main read port, combinational
  assign data_out = mem[addr];

  // debug read port, independent of the main address
  assign dbg_data = mem[dbg_addr];

endmodule

//--- src/register_file.sv
module register_file (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::reg_idx_t src_reg1,
  input  cpu_pkg::reg_idx_t src_reg2,
  input  cpu_pkg::reg_idx_t dst_reg,
  input  logic             write_reg,
  input  cpu_pkg::word_t   dst_data,
  output cpu_pkg::word_t   src_data1,
  output cpu_pkg::word_t   src_data2
);
  import cpu_pkg::*;

  word_t regs [16];

  // all registers cleared on reset and r0 never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write_reg && (dst_reg != 4'd0)) begin
      regs[dst_reg] <= dst_data;
    end
  end

  // a write lands at the edge, so the next instruction already
  // reads it from the array

  // r0 is forced to zero on both read ports
  always_comb begin
    if (src_reg1 == 4'd0) begin
      src_data1 = '0;
    end else begin
      src_data1 = regs[src_reg1];
    end
    if (src_reg2 == 4'd0) begin
      src_data2 = '0;
    end else begin
      src_data2 = regs[src_reg2];
    end
  end

endmodule

//--- src/alu.sv
module alu (
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  logic [7:0]       imm,
  input  logic             use_imm,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags
);
  import cpu_pkg::*;

  word_t       mem_offs;
  word_t       opnd_b;
  logic [3:0]  shamt;
  word_t       sum;
  word_t       diff;
  logic [31:0] rot_wide;
  logic        ovf_add;
  logic        ovf_sub;
  logic        ovf;

  // signed 4-bit word offset turned into a byte offset
  assign mem_offs = {{11{imm[3]}}, imm[3:0], 1'b0};
  assign opnd_b   = use_imm ? mem_offs : b;
  // shift amount from the immediate field
  assign shamt    = imm[3:0];

  assign sum  = a + opnd_b;
  assign diff = a - opnd_b;

  // signed overflow when operands agree in sign but the result does not
  assign ovf_add = (a[15] == opnd_b[15]) && (sum[15] != a[15]);
  // for subtract the operand signs must differ
  assign ovf_sub = (a[15] != opnd_b[15]) && (diff[15] != a[15]);

  // rotate by shifting a doubled copy
  assign rot_wide = {a, a} >> shamt;

  always_comb begin
    case (op)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_XOR: result = a ^ opnd_b;
      ALU_AND: result = a & opnd_b;
      ALU_SLL: result = a << shamt;
      ALU_SRA: result = $signed(a) >>> shamt;
      ALU_ROR: result = rot_wide[15:0];
      // low byte replaced and high byte kept
      ALU_LLB: result = {a[15:8], imm};
      // high byte replaced and low byte kept
      ALU_LHB: result = {imm, a[7:0]};
      default: result = sum;
    endcase
  end

  // v only means something for add and sub
  always_comb begin
    case (op)
      ALU_ADD: ovf = ovf_add;
      ALU_SUB: ovf = ovf_sub;
      default: ovf = 1'b0;
    endcase
  end

  // the flag register decides which bits it keeps
  assign flags[FLAG_Z] = (result == '0);
  assign flags[FLAG_V] = ovf;
  assign flags[FLAG_N] = result[15];

endmodule

//--- src/cpu_control.sv
`include "cpu_config.svh"

module cpu_control (
  input  cpu_pkg::opcode_t opcode,
  output cpu_pkg::alu_op_t alu_op,
  output logic             reg_write,
  output logic             mem_write,
  output logic             mem_to_reg,
  output logic             pcs_to_reg,
  output logic             src1_from_rd,
  output logic             src2_from_rd,
  output logic             alu_imm,
  output logic             set_zvn,
  output logic             set_z,
  output logic             is_branch,
  output logic             is_branch_reg,
  output logic             halt
);
  import cpu_pkg::*;

  always_comb begin
    // everything idle unless the opcode asks for it
    alu_op        = ALU_ADD;
    reg_write     = 1'b0;
    mem_write     = 1'b0;
    mem_to_reg    = 1'b0;
    pcs_to_reg    = 1'b0;
    src1_from_rd  = 1'b0;
    src2_from_rd  = 1'b0;
    alu_imm       = 1'b0;
    set_zvn       = 1'b0;
    set_z         = 1'b0;
    is_branch     = 1'b0;
    is_branch_reg = 1'b0;
    halt          = 1'b0;
    case (opcode)
      // arithmetic writes all three flags
      `CPU_OP_ADD: begin
        alu_op    = ALU_ADD;
        reg_write = 1'b1;
        set_zvn   = 1'b1;
      end
      `CPU_OP_SUB: begin
        alu_op    = ALU_SUB;
        reg_write = 1'b1;
        set_zvn   = 1'b1;
      end
      // logic ops only touch z
      `CPU_OP_XOR: begin
        alu_op    = ALU_XOR;
        reg_write = 1'b1;
        set_z     = 1'b1;
      end
      `CPU_OP_AND: begin
        alu_op    = ALU_AND;
        reg_write = 1'b1;
        set_z     = 1'b1;
      end
      // shifts take the amount from instr[3:0]
      `CPU_OP_SLL, `CPU_OP_SRA, `CPU_OP_ROR: begin
        alu_op    = (opcode == `CPU_OP_SLL) ? ALU_SLL :
                    (opcode == `CPU_OP_SRA) ? ALU_SRA : ALU_ROR;
        reg_write = 1'b1;
        set_z     = 1'b1;
        alu_imm   = 1'b1;
      end
      // base plus scaled offset, result back from memory
      `CPU_OP_LW: begin
        alu_imm    = 1'b1;
        reg_write  = 1'b1;
        mem_to_reg = 1'b1;
      end
      // store data comes from the register in [11:8]
      `CPU_OP_SW: begin
        alu_imm      = 1'b1;
        mem_write    = 1'b1;
        src2_from_rd = 1'b1;
      end
      // byte loads keep the other half of rd
      `CPU_OP_LLB, `CPU_OP_LHB: begin
        alu_op       = (opcode == `CPU_OP_LLB) ? ALU_LLB : ALU_LHB;
        reg_write    = 1'b1;
        src1_from_rd = 1'b1;
      end
      `CPU_OP_B:   is_branch     = 1'b1;
      `CPU_OP_BR:  is_branch_reg = 1'b1;
      `CPU_OP_PCS: begin
        reg_write  = 1'b1;
        pcs_to_reg = 1'b1;
      end
      `CPU_OP_HLT: halt = 1'b1;
      // nop falls through with all enables low
      default: ;
    endcase
  end

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

  // data, address and instruction word
  typedef logic [15:0] word_t;

  // register number, r0 reads as zero
  typedef logic [3:0] reg_idx_t;

  // instr[15:12]
  typedef logic [3:0] opcode_t;

  // branch condition, instr[11:9]
  typedef logic [2:0] cond_t;

  // stored flags, {z, v, n}
  typedef logic [2:0] flags_t;

  // bit positions inside flags_t
  localparam int unsigned FLAG_Z = 2;
  localparam int unsigned FLAG_V = 1;
  localparam int unsigned FLAG_N = 0;

  // alu function select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_AND,
    ALU_SLL,
    ALU_SRA,
    ALU_ROR,
    // byte merges for llb and lhb
    ALU_LLB,
    ALU_LHB
  } alu_op_t;

endpackage

//--- src/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// memory geometry, both memories share it
`define CPU_MEM_WORDS 1024
// word index width, byte address bits [10:1]
`define CPU_MEM_AW 10

// opcode map, taken from instr[15:12]
`define CPU_OP_ADD 4'h0
`define CPU_OP_SUB 4'h1
`define CPU_OP_XOR 4'h2
`define CPU_OP_AND 4'h3
`define CPU_OP_SLL 4'h4
`define CPU_OP_SRA 4'h5
`define CPU_OP_ROR 4'h6
// opcode 7 does nothing
`define CPU_OP_NOP 4'h7
`define CPU_OP_LW  4'h8
`define CPU_OP_SW  4'h9
`define CPU_OP_LLB 4'hA
`define CPU_OP_LHB 4'hB
`define CPU_OP_B   4'hC
`define CPU_OP_BR  4'hD
`define CPU_OP_PCS 4'hE
`define CPU_OP_HLT 4'hF

`endif
